// ==== test/audio_vectors.txt ====
# gain  mic_code  expected_sample  expected_led   (all hex)
# Sample is the I2S left word, led is the bar after a full meter window
0 800 0000 0
0 000 e000 3
0 fff 1ffc 3
0 801 0004 0
0 7ff fffc 0
0 a00 0800 1
0 900 0400 0
1 900 0800 1
2 900 1000 1
3 900 2000 3
0 700 fc00 0
1 700 f800 1
3 700 e000 3
1 b00 1800 3
2 500 d000 7
2 c00 4000 7
2 e00 6000 f
3 fff 7fff f
3 000 8000 f
3 c00 7fff f
3 400 8000 f
3 3ff 8000 f
0 800 0000 0

// ==== sources.f ====
common/audio_pkg.sv
mic/mic_spi_receiver.sv
hdl/sample_gain.sv
hdl/level_meter.sv
i2s/i2s_transmitter.sv
hdl/audio_loopback_top.sv
test/tb_audio_loopback.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tb_audio_loopback
RTL_TOP   ?= audio_loopback_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_audio_loopback.sv ====
`timescale 1ns/1ns

module tb_audio_loopback;

    localparam int CLK_PERIOD   = 4;
    localparam int FRAME_CLKS   = 4 * audio_pkg::BCLK_HALF * audio_pkg::SLOT_BITS;
    localparam int AUDIO_HOLD   = 3;  // I2S frames before the word check
    localparam int METER_HOLD   = 4;  // Further frames until a clean meter window
    localparam int WATCH_FRAMES = 8;
    localparam int LEAD_ZEROS   = audio_pkg::MIC_BITS - audio_pkg::MIC_W;
    localparam     VECTOR_FILE  = "test/audio_vectors.txt";

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic                            sdo = 1'b0;
    audio_pkg::gain_t                gain;
    logic                            cs;
    logic                            sck;
    logic                            mclk;
    logic                            bclk;
    logic                            lrclk;
    logic                            sdata;
    audio_pkg::led_bar_t             led;

    audio_pkg::gain_t                vec_gain[$];
    audio_pkg::mic_code_t            vec_code[$];
    logic [audio_pkg::SAMPLE_W-1:0]  vec_sample[$];
    audio_pkg::led_bar_t             vec_led[$];
    bit                              vectors_loaded = 1'b0;
    longint                          watchdog_ns;

    audio_pkg::mic_code_t            mic_code;     // Code the ADC model sends
    audio_pkg::mic_code_t            frame_code;
    logic                            sck_seen;
    int                              mic_bit;

    logic                            bclk_seen;
    logic                            lrclk_seen;
    logic                            sdata_seen;
    logic                            lr_at_rise;
    logic [audio_pkg::SAMPLE_W-1:0]  word_sh;
    logic [audio_pkg::SAMPLE_W-1:0]  left_word;
    int                              frame_count;  // Stereo frames captured

    logic                            mclk_seen;
    logic                            rst_seen = 1'b0;
    int                              mclk_run;     // Cycles since mclk last toggled

    audio_loopback_top u_dut (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .cs    ( cs    ),
        .sck   ( sck   ),
        .sdo   ( sdo   ),
        .mclk  ( mclk  ),
        .bclk  ( bclk  ),
        .lrclk ( lrclk ),
        .sdata ( sdata ),
        .gain  ( gain  ),
        .led   ( led   )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, expected);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] g, c, s, l;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the vector file %s", VECTOR_FILE);
            $display("Simulation FAILED");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin  // Skip blanks and comments
                fields = $sscanf(line, "%h %h %h %h", g, c, s, l);
                if (fields != 4) begin
                    $display("Vector line cannot be parsed: %s", line);
                    $display("Simulation FAILED");
                    $fatal(1);
                end
                vec_gain.push_back(g[audio_pkg::GAIN_W-1:0]);
                vec_code.push_back(c[audio_pkg::MIC_W-1:0]);
                vec_sample.push_back(s[audio_pkg::SAMPLE_W-1:0]);
                vec_led.push_back(l[audio_pkg::LED_W-1:0]);
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_frames(input int frames);
        int target;
        target = frame_count + frames;
        while (frame_count < target) begin
            @(posedge clk);
        end
    endtask

    task automatic check_reset_outputs();
        check_value("cs", cs, 1'b1);
        check_value("mclk", mclk, 1'b0);
        check_value("lrclk", lrclk, 1'b0);
        check_value("sdata", sdata, 1'b0);
        check_value("led", led, '0);
    endtask

    //----------------------------------------------------------------------
    // ADC model, one code per frame, 4 zeros then 12 bits MSB first

    always @(posedge clk) begin
        sck_seen <= sck;
        if (!rst_n || cs) begin
            mic_bit <= 0;
            sdo     <= 1'b0;
        end else if (sck_seen && !sck) begin  // sck fell on the previous edge
            if (mic_bit == 0) begin
                frame_code <= mic_code;  // No torn frames
            end
            sdo     <= (mic_bit < LEAD_ZEROS) ? 1'b0 :
                       frame_code[audio_pkg::MIC_BITS - 1 - mic_bit];
            mic_bit <= mic_bit + 1;
        end
    end

    //----------------------------------------------------------------------
    // I2S capture on rising bclk, words split at lrclk changes

    always @(posedge clk) begin : capture_i2s
        logic [audio_pkg::SAMPLE_W-1:0] shifted;
        bclk_seen  <= bclk;
        lrclk_seen <= lrclk;
        sdata_seen <= sdata;
        shifted = {word_sh[audio_pkg::SAMPLE_W-2:0], sdata};
        if (!rst_n) begin
            word_sh     <= '0;
            lr_at_rise  <= 1'b0;
            frame_count <= 0;
        end else begin
            if (lrclk !== lrclk_seen || sdata !== sdata_seen) begin
                check_value("bclk at lrclk or sdata change", {bclk_seen, bclk}, 2'b10);
            end
            if (!bclk_seen && bclk) begin
                word_sh    <= shifted;
                lr_at_rise <= lrclk;
                if (lrclk != lr_at_rise) begin  // Last bit of the previous slot
                    if (!lr_at_rise) begin
                        left_word <= shifted;
                    end else begin
                        check_value("right word", shifted, left_word);
                        frame_count <= frame_count + 1;
                    end
                end
            end
        end
    end

    //----------------------------------------------------------------------
    // Codec master clock, one toggle every MCLK_HALF clk cycles

    always @(posedge clk) begin
        mclk_seen <= mclk;
        rst_seen  <= rst_n;
        if (!rst_seen) begin
            mclk_run <= 0;
        end else if (mclk !== mclk_seen) begin
            check_value("mclk half period", mclk_run + 1, audio_pkg::MCLK_HALF);
            mclk_run <= 0;
        end else if (mclk_run + 1 >= audio_pkg::MCLK_HALF) begin
            $display("mclk stopped toggling");
            $display("Simulation FAILED");
            $fatal(1);
        end else begin
            mclk_run <= mclk_run + 1;
        end
    end

    //----------------------------------------------------------------------

    initial begin : main
        int gap;
        rst_n    = 1'b0;
        gain     = '0;
        mic_code = audio_pkg::MIC_OFFSET;
        void'($urandom(32'hf3104452));
        load_vectors();
        if (vec_gain.size() == 0) begin
            $display("The vector file holds no tests");
            $display("Simulation FAILED");
            $fatal(1);
        end
        watchdog_ns = longint'(vec_gain.size()) * WATCH_FRAMES * FRAME_CLKS * CLK_PERIOD
                      + 20000;
        vectors_loaded = 1'b1;

        repeat (4) @(posedge clk);
        check_reset_outputs();
        rst_n <= 1'b1;
        @(posedge clk);
        check_reset_outputs();  // Last reset values still on the pins

        for (int i = 0; i < vec_gain.size(); i++) begin
            gap = $urandom % 64;
            repeat (gap) @(posedge clk);
            gain     <= vec_gain[i];
            mic_code <= vec_code[i];
            wait_frames(AUDIO_HOLD);
            check_value("left word", left_word, vec_sample[i]);
            wait_frames(METER_HOLD);
            check_value("led", led, vec_led[i]);
        end
        $display("Simulation PASSED");
        $finish;
    end

    initial begin : watchdog
        wait (vectors_loaded);
        #(watchdog_ns);
        $display("Timeout after %0d ns, the tests did not finish", watchdog_ns);
        $display("Simulation FAILED");
        $fatal(1);
    end

endmodule

// ==== hdl/audio_loopback_top.sv ====
`timescale 1ns/1ns

module audio_loopback_top (
    input  logic                clk,
    input  logic                rst_n,

    output logic                cs,
    output logic                sck,
    input  logic                sdo,

    output logic                mclk,
    output logic                bclk,
    output logic                lrclk,
    output logic                sdata,

    input  audio_pkg::gain_t    gain,
    output audio_pkg::led_bar_t led
);

    audio_pkg::mic_beat_t    mic_beat;
    audio_pkg::sample_beat_t sample_beat;

    //--------------------------------------------------------------------

    mic_spi_receiver i_mic_spi_receiver (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .cs          ( cs          ),
        .sck         ( sck         ),
        .sdo         ( sdo         ),
        .mic_beat    ( mic_beat    )
    );

    sample_gain i_sample_gain (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .mic_beat    ( mic_beat    ),
        .gain        ( gain        ),
        .sample_beat ( sample_beat )
    );

    //--------------------------------------------------------------------
    // Fork to the codec and the LED bar

    i2s_transmitter i_i2s_transmitter (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .sample_beat ( sample_beat ),
        .mclk        ( mclk        ),
        .bclk        ( bclk        ),
        .lrclk       ( lrclk       ),
        .sdata       ( sdata       )
    );

    level_meter i_level_meter (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .sample_beat ( sample_beat ),
        .led         ( led         )
    );

endmodule

// ==== i2s/i2s_transmitter.sv ====
`timescale 1ns/1ns

module i2s_transmitter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  audio_pkg::sample_beat_t sample_beat,
    output logic                    mclk,
    output logic                    bclk,
    output logic                    lrclk,
    output logic                    sdata
);

    audio_pkg::mclk_cnt_t     mclk_cnt;
    audio_pkg::bclk_cnt_t     bclk_cnt;
    audio_pkg::slot_cnt_t     bit_cnt;   // bclk period within the stereo frame
    audio_pkg::slot_cnt_t     bit_next;
    audio_pkg::audio_sample_t latest;    // Newest sample from the gain stage
    audio_pkg::audio_sample_t word;      // Frame word, reused for the right slot
    audio_pkg::audio_sample_t shreg;
    logic                     bclk_fall;

    assign bclk_fall = bclk && (bclk_cnt == audio_pkg::bclk_cnt_t'(audio_pkg::BCLK_HALF - 1));
    assign bit_next  = bit_cnt + 1'b1;

    //--------------------------------------------------------------------
    // Clock dividers

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mclk_cnt <= '0;
            mclk     <= 1'b0;
        end else if (mclk_cnt == audio_pkg::mclk_cnt_t'(audio_pkg::MCLK_HALF - 1)) begin
            mclk_cnt <= '0;
            mclk     <= ~mclk;
        end else begin
            mclk_cnt <= mclk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bclk_cnt <= '0;
            bclk     <= 1'b1;
        end else if (bclk_cnt == audio_pkg::bclk_cnt_t'(audio_pkg::BCLK_HALF - 1)) begin
            bclk_cnt <= '0;
            bclk     <= ~bclk;
        end else begin
            bclk_cnt <= bclk_cnt + 1'b1;
        end
    end

    //--------------------------------------------------------------------
    // Sample hold and serialiser

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            latest <= '0;  // Silence until the first sample
        end else if (sample_beat.valid) begin
            latest <= sample_beat.sample;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt <= '1;  // First falling edge opens a frame
            lrclk   <= 1'b0;
            sdata   <= 1'b0;
            word    <= '0;
            shreg   <= '0;
        end else if (bclk_fall) begin
            bit_cnt <= bit_next;
            lrclk   <= (bit_next >= audio_pkg::slot_cnt_t'(audio_pkg::SLOT_BITS));
            sdata   <= shreg[audio_pkg::SAMPLE_W-1];  // One bclk behind lrclk
            if (bit_next == '0) begin
                word  <= latest;
                shreg <= latest;
            end else if (bit_next == audio_pkg::slot_cnt_t'(audio_pkg::SLOT_BITS)) begin
                shreg <= word;  // Same sample on the right channel
            end else begin
                shreg <= shreg << 1;
            end
        end
    end

    // The codec samples on rising bclk, so data and word select move on the fall
    assert property (@(posedge clk) disable iff (!rst_n)
        ($changed(sdata) || $changed(lrclk)) |-> $fell(bclk));

endmodule

// ==== hdl/level_meter.sv ====
`timescale 1ns/1ns

module level_meter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  audio_pkg::sample_beat_t sample_beat,
    output audio_pkg::led_bar_t     led
);

    audio_pkg::meter_cnt_t           count;      // Samples seen in this window
    logic [audio_pkg::SAMPLE_W-1:0]  peak;
    logic [audio_pkg::SAMPLE_W-1:0]  peak_base;
    logic [audio_pkg::SAMPLE_W-1:0]  mag;
    logic                            done_q;     // Window just closed
    audio_pkg::led_bar_t             therm;

    // Absolute value, most negative code clipped to full scale
    always_comb begin
        mag = sample_beat.sample;
        if (sample_beat.sample[audio_pkg::SAMPLE_W-1]) begin
            if (sample_beat.sample == audio_pkg::SAMPLE_MIN) begin
                mag = audio_pkg::SAMPLE_MAX;
            end else begin
                mag = -sample_beat.sample;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < audio_pkg::LED_W; i++) begin
            therm[i] = (peak >= audio_pkg::METER_THRESHOLDS[i]);
        end
    end

    assign peak_base = done_q ? '0 : peak;  // Clear lands with a new sample

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count  <= '0;
            peak   <= '0;
            done_q <= 1'b0;
            led    <= '0;
        end else begin
            done_q <= 1'b0;
            if (done_q) begin
                led  <= therm;
                peak <= '0;
            end
            if (sample_beat.valid) begin
                peak <= (mag > peak_base) ? mag : peak_base;
                if (count == audio_pkg::meter_cnt_t'(audio_pkg::METER_WINDOW - 1)) begin
                    count  <= '0;
                    done_q <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // Holds only while the package thresholds stay in rising order
    assert property (@(posedge clk) disable iff (!rst_n)
        (led & (led + audio_pkg::led_bar_t'(1))) == '0);

endmodule

// ==== hdl/sample_gain.sv ====
`timescale 1ns/1ns

module sample_gain (
    input  logic                    clk,
    input  logic                    rst_n,
    input  audio_pkg::mic_beat_t    mic_beat,
    input  audio_pkg::gain_t        gain,
    output audio_pkg::sample_beat_t sample_beat
);

    audio_pkg::mic_code_t               centred;
    logic [2:0]                         shift;     // 2 to 5
    logic signed [audio_pkg::SAMPLE_W:0] wide;     // Guard bit above the sample
    audio_pkg::audio_sample_t           sat;
    logic                               valid_q;
    audio_pkg::audio_sample_t           sample_q;

    // Offset-binary to two's complement
    assign centred = mic_beat.code - audio_pkg::MIC_OFFSET;
    assign shift   = 3'(gain) + 3'(audio_pkg::GAIN_SHIFT_BASE);

    assign wide = $signed({{(audio_pkg::SAMPLE_W + 1 - audio_pkg::MIC_W){centred[audio_pkg::MIC_W-1]}},
                           centred}) <<< shift;

    // Guard bit disagrees with the sign bit means the shift overflowed
    always_comb begin
        if (wide[audio_pkg::SAMPLE_W] != wide[audio_pkg::SAMPLE_W-1]) begin
            sat = wide[audio_pkg::SAMPLE_W] ? audio_pkg::SAMPLE_MIN : audio_pkg::SAMPLE_MAX;
        end else begin
            sat = wide[audio_pkg::SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mic_beat.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mic_beat.valid) begin
            sample_q <= sat;
        end
    end

    assign sample_beat.valid  = valid_q;
    assign sample_beat.sample = sample_q;

    // Exactly one cycle through this stage
    assert property (@(posedge clk) disable iff (!rst_n)
        sample_beat.valid |-> $past(mic_beat.valid));

endmodule

// ==== mic/mic_spi_receiver.sv ====
`timescale 1ns/1ns

module mic_spi_receiver (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 cs,
    output logic                 sck,
    input  logic                 sdo,
    output audio_pkg::mic_beat_t mic_beat
);

    audio_pkg::mic_state_t          state;
    audio_pkg::mic_cnt_t            cnt;      // Half period or gap cycles
    audio_pkg::mic_bit_t            bit_cnt;  // sck periods done in the frame
    logic [audio_pkg::MIC_BITS-1:0] shreg;
    logic                           sck_rise;
    logic                           valid_q;
    audio_pkg::mic_code_t           code_q;

    assign sck_rise = (state == audio_pkg::SHIFT) && !sck &&
                      (cnt == audio_pkg::mic_cnt_t'(audio_pkg::SCK_HALF - 1));

    //--------------------------------------------------------------------
    // Frame FSM

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= audio_pkg::IDLE;
            cs      <= 1'b1;
            sck     <= 1'b1;
            cnt     <= '0;
            bit_cnt <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state)
                audio_pkg::IDLE: begin
                    cs    <= 1'b0;  // First frame starts right away
                    state <= audio_pkg::SHIFT;
                end
                audio_pkg::SHIFT: begin
                    if (cnt == audio_pkg::mic_cnt_t'(audio_pkg::SCK_HALF - 1)) begin
                        cnt <= '0;
                        sck <= ~sck;
                        if (sck_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == audio_pkg::mic_bit_t'(audio_pkg::MIC_BITS - 1)) begin
                                cs    <= 1'b1;  // Last rising edge ends the frame
                                state <= audio_pkg::GAP;
                            end
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                audio_pkg::GAP: begin
                    valid_q <= (cnt == '0);  // One cycle after cs goes high
                    if (cnt == audio_pkg::mic_cnt_t'(audio_pkg::MIC_GAP - 1)) begin
                        cnt   <= '0;
                        cs    <= 1'b0;
                        state <= audio_pkg::SHIFT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= audio_pkg::IDLE;
            endcase
        end
    end

    //--------------------------------------------------------------------
    // Data path

    always_ff @(posedge clk) begin
        if (sck_rise) begin
            shreg <= {shreg[audio_pkg::MIC_BITS-2:0], sdo};  // MSB first
        end
        if (state == audio_pkg::GAP && cnt == '0) begin
            code_q <= shreg[audio_pkg::MIC_W-1:0];  // Leading zeros dropped
        end
    end

    assign mic_beat.valid = valid_q;
    assign mic_beat.code  = code_q;

    // sck idles high between frames, so the ADC never sees a stray edge
    assert property (@(posedge clk) disable iff (!rst_n) cs |-> sck);

endmodule

// ==== common/audio_pkg.sv ====
package audio_pkg;

    //--------------------------------------------------------------------
    // Widths

    localparam int MIC_W    = 12;
    localparam int SAMPLE_W = 16;
    localparam int GAIN_W   = 2;
    localparam int LED_W    = 4;

    typedef logic        [MIC_W    - 1:0] mic_code_t;      // Offset-binary ADC code
    typedef logic signed [SAMPLE_W - 1:0] audio_sample_t;  // Signed PCM
    typedef logic        [GAIN_W   - 1:0] gain_t;          // Switch gain select
    typedef logic        [LED_W    - 1:0] led_bar_t;

    //--------------------------------------------------------------------
    // Rates and constants

    localparam mic_code_t     MIC_OFFSET      = 12'h800;   // Mid-scale code
    localparam int            GAIN_SHIFT_BASE = 2;         // Shift is this plus gain
    localparam audio_sample_t SAMPLE_MAX      = 16'sh7FFF;
    localparam audio_sample_t SAMPLE_MIN      = 16'sh8000;

    localparam int SCK_HALF     = 2;   // clk cycles per sck half period
    localparam int MIC_BITS     = 16;  // 4 leading zeros, then 12 data bits
    localparam int MIC_GAP      = 8;   // cs high between frames
    localparam int BCLK_HALF    = 4;
    localparam int MCLK_HALF    = 1;
    localparam int SLOT_BITS    = 16;  // bclk periods per channel
    localparam int METER_WINDOW = 8;   // Samples per peak window

    // Entry 0 is the lowest LED
    localparam logic [LED_W - 1:0][SAMPLE_W - 1:0] METER_THRESHOLDS =
        {16'h6000, 16'h3000, 16'h1800, 16'h0800};

    typedef logic [$clog2(MIC_GAP)       - 1:0] mic_cnt_t;  // Also covers SCK_HALF
    typedef logic [$clog2(MIC_BITS)      - 1:0] mic_bit_t;
    typedef logic [$clog2(BCLK_HALF)     - 1:0] bclk_cnt_t;
    typedef logic [$clog2(MCLK_HALF + 1) - 1:0] mclk_cnt_t;
    typedef logic [$clog2(2 * SLOT_BITS) - 1:0] slot_cnt_t;  // Both slots of a frame
    typedef logic [$clog2(METER_WINDOW)  - 1:0] meter_cnt_t;

    //--------------------------------------------------------------------
    // Beats between stages

    typedef struct packed {
        logic      valid;
        mic_code_t code;
    } mic_beat_t;

    typedef struct packed {
        logic          valid;
        audio_sample_t sample;
    } sample_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        GAP
    } mic_state_t;

endpackage
